/* hw/zxuno_macros.svh */
`ifndef ZXUNO_MACROS_SVH
`define ZXUNO_MACROS_SVH

// ---------------------
// cpu i/o ports of the register bank
`define ZXUNO_ADDR_PORT 16'hFC3B
`define ZXUNO_DATA_PORT 16'hFD3B

// ---------------------
// register numbers behind the address port
`define REG_SCANDBL    8'h0B
`define REG_RASTERLINE 8'h0C
`define REG_RASTERCTRL 8'h0D
`define REG_DEVOPTIONS 8'h0E
`define REG_SCRATCH    8'hFE
`define REG_COREID     8'hFF

// core identification, first character in the top byte
`define COREID_LEN    8
`define COREID_STRING "ZXURB-01"

// ---------------------
// values after reset
`define REGADDR_RESET    8'h00
`define CFG_RESET        8'h00
`define RASTERLINE_RESET 9'h000

`endif

/* hw/zxuno_pkg.sv */
package zxuno_pkg;

  // --------------------
  // basic bus quantities

  // register number as latched from the address port
  typedef logic [7:0] reg_addr_t;

  // one byte on the cpu data bus
  typedef logic [7:0] cpu_byte_t;

  // raster line, 9 bits wide like the ula vertical counter
  typedef logic [8:0] raster_line_t;

  // --------------------
  // register payloads, msb first

  // scandoubler and turbo control
  typedef struct packed {
    logic [1:0] turbo_option;      // bits 7:6, cpu speed select
    logic       csync_option;      // bit 5
    logic [2:0] freq_option;       // bits 4:2, vertical frequency
    logic       scanlines_enable;  // bit 1
    logic       vga_enable;        // bit 0
  } scandbl_ctrl_t;

  // device enable options, one bit per device
  typedef struct packed {
    logic disable_spisd;     // bit 7
    logic enable_timexmmu;   // bit 6, the only active-high enable
    logic disable_romsel1f;  // bit 5
    logic disable_romsel7f;  // bit 4
    logic disable_1ffd;      // bit 3
    logic disable_7ffd;      // bit 2
    logic disable_turboay;   // bit 1
    logic disable_ay;        // bit 0
  } dev_options_t;

endpackage

/* hw/zxreg_if.sv */
`timescale 1ns/100ps

// register bank bus from the port decoder to every register target
// strobes only, targets have no way to stall the cpu
interface zxreg_if;

  // latched register number
  zxuno_pkg::reg_addr_t addr;
  // byte captured from the cpu on a data port write
  zxuno_pkg::cpu_byte_t wdata;
  // data port read in progress, follows the cpu strobe
  logic regrd;
  // single pulse per data port write
  logic regwr;
  // single pulse per address port write
  logic regaddr_changed;

  modport decoder (
    output addr, wdata, regrd, regwr, regaddr_changed
  );

  modport target (
    input addr, wdata, regrd, regwr, regaddr_changed
  );

endinterface

/* hw/zxuno_regs.sv */
`timescale 1ns/100ps
`include "zxuno_macros.svh"

module zxuno_regs (
  input  logic                 sysclk,
  input  logic                 rst_n,
  // cpu i/o cycle
  input  logic [15:0]          cpu_addr,
  input  logic                 iorq_n,
  input  logic                 rd_n,
  input  logic                 wr_n,
  input  zxuno_pkg::cpu_byte_t cpu_dout,
  // readback of the address port
  output zxuno_pkg::cpu_byte_t addr_dout,
  output logic                 addr_oe,
  // to the register targets
  zxreg_if.decoder             bus
);
  import zxuno_pkg::*;

  logic      addr_sel;
  logic      data_sel;
  logic      rd_cyc;
  logic      wr_cyc;
  logic      addr_wr;
  logic      data_wr;
  logic      addr_wr_q;
  logic      data_wr_q;
  logic      addr_wr_start;
  logic      data_wr_start;
  logic      regwr_q;
  logic      addr_chg_q;
  reg_addr_t reg_addr;
  cpu_byte_t wdata_q;

  // --------------------
  // port decode, full 16 bit match on both ports
  assign addr_sel = (cpu_addr == `ZXUNO_ADDR_PORT);
  assign data_sel = (cpu_addr == `ZXUNO_DATA_PORT);
  assign rd_cyc   = ~iorq_n & ~rd_n;
  assign wr_cyc   = ~iorq_n & ~wr_n;
  assign addr_wr  = addr_sel & wr_cyc;
  assign data_wr  = data_sel & wr_cyc;

  // leading edge only, a long strobe writes once
  assign addr_wr_start = addr_wr & ~addr_wr_q;
  assign data_wr_start = data_wr & ~data_wr_q;

  always_ff @(posedge sysclk or negedge rst_n) begin
    if (!rst_n) begin
      addr_wr_q  <= 1'b0;
      data_wr_q  <= 1'b0;
      regwr_q    <= 1'b0;
      addr_chg_q <= 1'b0;
      reg_addr   <= `REGADDR_RESET;
    end else begin
      addr_wr_q  <= addr_wr;
      data_wr_q  <= data_wr;
      // pulses land together with the captured data
      regwr_q    <= data_wr_start;
      addr_chg_q <= addr_wr_start;
      if (addr_wr_start) begin
        reg_addr <= cpu_dout;
      end
    end
  end

  // write byte held until the next data port write
  always_ff @(posedge sysclk) begin
    if (data_wr_start) begin
      wdata_q <= cpu_dout;
    end
  end

  // --------------------
  // outputs
  assign addr_dout           = reg_addr;
  assign addr_oe             = addr_sel & rd_cyc;
  assign bus.addr            = reg_addr;
  assign bus.wdata           = wdata_q;
  assign bus.regrd           = data_sel & rd_cyc;
  assign bus.regwr           = regwr_q;
  assign bus.regaddr_changed = addr_chg_q;

  // write pulse trails its strobe, a read must not start under it
  assert property (@(posedge sysclk) disable iff (!rst_n)
    !(bus.regrd && bus.regwr));

endmodule

/* hw/cfg_register.sv */
`timescale 1ns/100ps
`include "zxuno_macros.svh"

module cfg_register #(
  parameter type                  payload_t = zxuno_pkg::cpu_byte_t,
  parameter zxuno_pkg::reg_addr_t REG_NUM   = 8'h00
) (
  input  logic                 sysclk,
  input  logic                 rst_n,
  // register bank bus
  zxreg_if.target              bus,
  // current contents, fields go straight out of the core
  output payload_t             value,
  // readback to the cpu mux
  output zxuno_pkg::cpu_byte_t dout,
  output logic                 oe
);
  import zxuno_pkg::*;

  logic hit;
  logic wr_hit;

  // payload has to fill the whole data byte
  if ($bits(payload_t) != 8) begin : g_width_check
    $error("cfg_register payload is not one byte wide");
  end

  // selected when the latched number is ours
  assign hit    = (bus.addr == REG_NUM);
  assign wr_hit = hit & bus.regwr;

  // --------------------
  // storage
  always_ff @(posedge sysclk or negedge rst_n) begin
    if (!rst_n) begin
      value <= payload_t'(`CFG_RESET);
    end else if (wr_hit) begin
      value <= payload_t'(bus.wdata);
    end
  end

  // --------------------
  // readback while the data port is read
  assign dout = cpu_byte_t'(value);
  assign oe   = hit & bus.regrd;

endmodule

/* hw/coreid_rom.sv */
`timescale 1ns/100ps
`include "zxuno_macros.svh"

module coreid_rom (
  input  logic                 sysclk,
  input  logic                 rst_n,
  // register bank bus
  zxreg_if.target              bus,
  // one character per read
  output zxuno_pkg::cpu_byte_t dout,
  output logic                 oe
);
  import zxuno_pkg::*;

  // pointer counts up to the length, which means end of string
  localparam int PTR_W = $clog2(`COREID_LEN + 1);
  localparam logic [8*`COREID_LEN-1:0] ID_STR = `COREID_STRING;

  logic [PTR_W-1:0]         ptr;
  logic [8*`COREID_LEN-1:0] id_window;
  logic                     id_hit;
  logic                     id_rd;
  logic                     id_rd_q;
  logic                     rd_done;
  cpu_byte_t                id_char;

  assign id_hit = (bus.addr == `REG_COREID);
  assign id_rd  = id_hit & bus.regrd;

  // read strobe just ended
  assign rd_done = id_rd_q & ~id_rd;

  // --------------------
  // character select
  // shifting the string left moves char ptr to the top byte
  // past the end only zeros are left
  assign id_window = ID_STR << (8 * ptr);
  assign id_char   = id_window[8*`COREID_LEN-1 -: 8];

  // --------------------
  // pointer
  always_ff @(posedge sysclk or negedge rst_n) begin
    if (!rst_n) begin
      ptr     <= '0;
      id_rd_q <= 1'b0;
    end else begin
      id_rd_q <= id_rd;
      if (bus.regaddr_changed) begin
        // new selection starts over
        ptr <= '0;
      end else if (rd_done && ptr != PTR_W'(`COREID_LEN)) begin
        ptr <= ptr + 1'b1;
      end
    end
  end

  assign dout = id_char;
  assign oe   = id_rd;

endmodule

/* hw/rasterint_ctrl.sv */
`timescale 1ns/100ps
`include "zxuno_macros.svh"

module rasterint_ctrl (
  input  logic                    sysclk,
  input  logic                    rst_n,
  // register bank bus
  zxreg_if.target                 bus,
  // current raster line from the video counters
  input  zxuno_pkg::raster_line_t vcnt,
  // readback to the cpu mux
  output zxuno_pkg::cpu_byte_t    dout,
  output logic                    oe,
  // interrupt request, active low
  output logic                    raster_int_n
);
  import zxuno_pkg::*;

  raster_line_t raster_line;
  logic         enable;
  logic         vretrace_disable;
  logic         in_progress;
  logic         line_hit;
  logic         ctrl_hit;
  logic         ctrl_wr;
  logic         ctrl_rd;
  logic         ctrl_rd_q;
  logic         match;
  logic         match_q;
  cpu_byte_t    ctrl_byte;

  assign line_hit = (bus.addr == `REG_RASTERLINE);
  assign ctrl_hit = (bus.addr == `REG_RASTERCTRL);
  assign ctrl_wr  = ctrl_hit & bus.regwr;
  assign ctrl_rd  = ctrl_hit & bus.regrd;

  // line compare, only counts while enabled
  assign match = enable & (vcnt == raster_line);

  // ctrl layout: 3 in progress, 2 vretrace off, 1 enable, 0 line msb
  assign ctrl_byte = {4'b0000, in_progress, vretrace_disable, enable, raster_line[8]};

  // --------------------
  // registers and interrupt flag
  always_ff @(posedge sysclk or negedge rst_n) begin
    if (!rst_n) begin
      raster_line      <= `RASTERLINE_RESET;
      enable           <= 1'b0;
      vretrace_disable <= 1'b0;
      in_progress      <= 1'b0;
      ctrl_rd_q        <= 1'b0;
      match_q          <= 1'b0;
    end else begin
      ctrl_rd_q <= ctrl_rd;
      match_q   <= match;
      if (line_hit && bus.regwr) begin
        raster_line[7:0] <= bus.wdata;
      end
      if (ctrl_wr) begin
        raster_line[8]   <= bus.wdata[0];
        enable           <= bus.wdata[1];
        vretrace_disable <= bus.wdata[2];
      end
      // ack by reading ctrl, or drop it when disabled
      if ((ctrl_rd_q && !ctrl_rd) || (ctrl_wr && !bus.wdata[1])) begin
        in_progress <= 1'b0;
      end else if (match && !match_q) begin
        // fire once on entering the line
        in_progress <= 1'b1;
      end
    end
  end

  // --------------------
  // outputs
  assign dout         = ctrl_hit ? ctrl_byte : raster_line[7:0];
  assign oe           = (line_hit | ctrl_hit) & bus.regrd;
  assign raster_int_n = ~in_progress;

  // no pending interrupt survives a disable
  assert property (@(posedge sysclk) disable iff (!rst_n)
    !raster_int_n |-> enable);

endmodule

/* hw/cpu_din_mux.sv */
`timescale 1ns/100ps

module cpu_din_mux (
  // address port readback
  input  logic                 addr_oe,
  input  zxuno_pkg::cpu_byte_t addr_dout,
  // configuration registers
  input  logic                 scandbl_oe,
  input  zxuno_pkg::cpu_byte_t scandbl_dout,
  input  logic                 devopt_oe,
  input  zxuno_pkg::cpu_byte_t devopt_dout,
  input  logic                 scratch_oe,
  input  zxuno_pkg::cpu_byte_t scratch_dout,
  // raster interrupt and core id
  input  logic                 raster_oe,
  input  zxuno_pkg::cpu_byte_t raster_dout,
  input  logic                 coreid_oe,
  input  zxuno_pkg::cpu_byte_t coreid_dout,
  // to the cpu
  output zxuno_pkg::cpu_byte_t cpu_din,
  output logic                 cpu_oe
);
  import zxuno_pkg::*;

  // floating bus reads as all ones
  localparam cpu_byte_t IDLE_BYTE = 8'hFF;

  // first source with oe wins
  always_comb begin
    priority case (1'b1)
      addr_oe:    cpu_din = addr_dout;
      scandbl_oe: cpu_din = scandbl_dout;
      devopt_oe:  cpu_din = devopt_dout;
      scratch_oe: cpu_din = scratch_dout;
      raster_oe:  cpu_din = raster_dout;
      coreid_oe:  cpu_din = coreid_dout;
      default:    cpu_din = IDLE_BYTE;
    endcase
  end

  assign cpu_oe = addr_oe | scandbl_oe | devopt_oe | scratch_oe | raster_oe | coreid_oe;

  // register decode in the targets never overlaps
  always_comb begin
    assert final ($onehot0({addr_oe, scandbl_oe, devopt_oe, scratch_oe, raster_oe, coreid_oe}))
      else $error("cpu_din_mux: more than one oe active");
  end

endmodule

/* hw/zxuno_core.sv */
`timescale 1ns/100ps
`include "zxuno_macros.svh"

module zxuno_core (
  input  logic                    sysclk,
  input  logic                    rst_n,
  // cpu bus
  input  logic [15:0]             cpu_addr,
  input  logic                    iorq_n,
  input  logic                    rd_n,
  input  logic                    wr_n,
  input  zxuno_pkg::cpu_byte_t    cpu_dout,
  output zxuno_pkg::cpu_byte_t    cpu_din,
  output logic                    cpu_oe,
  // video side
  input  zxuno_pkg::raster_line_t vcnt,
  output logic                    raster_int_n,
  // scandoubler control
  output logic                    vga_enable,
  output logic                    scanlines_enable,
  output logic [2:0]              freq_option,
  output logic [1:0]              turbo_option,
  output logic                    csync_option,
  // device enables
  output logic [7:0]              dev_options
);
  import zxuno_pkg::*;

  zxreg_if regbus ();

  scandbl_ctrl_t scandbl;
  dev_options_t  devopt;
  cpu_byte_t     addr_dout;
  cpu_byte_t     scandbl_dout;
  cpu_byte_t     devopt_dout;
  cpu_byte_t     scratch_dout;
  cpu_byte_t     raster_dout;
  cpu_byte_t     coreid_dout;
  logic          addr_oe;
  logic          scandbl_oe;
  logic          devopt_oe;
  logic          scratch_oe;
  logic          raster_oe;
  logic          coreid_oe;

  // --------------------
  // port decode
  zxuno_regs u_regs (
    .sysclk, .rst_n, .cpu_addr, .iorq_n, .rd_n, .wr_n, .cpu_dout,
    .addr_dout, .addr_oe, .bus(regbus.decoder)
  );

  // --------------------
  // register targets
  cfg_register #(.payload_t(scandbl_ctrl_t), .REG_NUM(`REG_SCANDBL)) u_scandbl (
    .sysclk, .rst_n, .bus(regbus.target),
    .value(scandbl), .dout(scandbl_dout), .oe(scandbl_oe)
  );

  cfg_register #(.payload_t(dev_options_t), .REG_NUM(`REG_DEVOPTIONS)) u_devopt (
    .sysclk, .rst_n, .bus(regbus.target),
    .value(devopt), .dout(devopt_dout), .oe(devopt_oe)
  );

  // scratch byte, only the cpu looks at it
  cfg_register #(.payload_t(cpu_byte_t), .REG_NUM(`REG_SCRATCH)) u_scratch (
    .sysclk, .rst_n, .bus(regbus.target),
    .value(), .dout(scratch_dout), .oe(scratch_oe)
  );

  coreid_rom u_coreid (
    .sysclk, .rst_n, .bus(regbus.target), .dout(coreid_dout), .oe(coreid_oe)
  );

  rasterint_ctrl u_rasterint (
    .sysclk, .rst_n, .bus(regbus.target), .vcnt,
    .dout(raster_dout), .oe(raster_oe), .raster_int_n
  );

  // --------------------
  // cpu read path
  cpu_din_mux u_din_mux (
    .addr_oe, .addr_dout, .scandbl_oe, .scandbl_dout, .devopt_oe, .devopt_dout,
    .scratch_oe, .scratch_dout, .raster_oe, .raster_dout, .coreid_oe, .coreid_dout,
    .cpu_din, .cpu_oe
  );

  // config fields out to the board
  assign vga_enable       = scandbl.vga_enable;
  assign scanlines_enable = scandbl.scanlines_enable;
  assign freq_option      = scandbl.freq_option;
  assign turbo_option     = scandbl.turbo_option;
  assign csync_option     = scandbl.csync_option;
  assign dev_options      = devopt;

endmodule

/* bench/tb_zxuno_core.sv */
`timescale 1ns/100ps
`include "zxuno_macros.svh"

module tb_zxuno_core;
  import zxuno_pkg::*;

  localparam int TIMEOUT_CYCLES = 5000;
  localparam logic [8*`COREID_LEN-1:0] ID_STR = `COREID_STRING;
  localparam raster_line_t IRQ_LINE = 9'h1A5;

  // dut ports
  logic         sysclk;
  logic         rst_n;
  logic [15:0]  cpu_addr;
  logic         iorq_n;
  logic         rd_n;
  logic         wr_n;
  cpu_byte_t    cpu_dout;
  cpu_byte_t    cpu_din;
  logic         cpu_oe;
  raster_line_t vcnt;
  logic         raster_int_n;
  logic         vga_enable;
  logic         scanlines_enable;
  logic [2:0]   freq_option;
  logic [1:0]   turbo_option;
  logic         csync_option;
  logic [7:0]   dev_options;
  cpu_byte_t    scandbl_out;

  // expected register bank state
  reg_addr_t    exp_reg;
  cpu_byte_t    exp_scandbl;
  cpu_byte_t    exp_devopt;
  cpu_byte_t    exp_scratch;
  raster_line_t exp_line;
  logic         exp_en;
  logic         exp_vrd;
  logic         exp_pend;
  int           exp_idx;
  // expected read response, valid while rd_check
  cpu_byte_t    exp_din;
  logic         exp_oe;
  logic         rd_check;

  int          rd_errors;
  int          cfg_errors;
  int          int_errors;
  int          strobe_errors;
  int          regwr_cnt;
  int          addr_chg_cnt;
  int          cycle_cnt = 0;

  zxuno_core u_dut (
    .sysclk, .rst_n, .cpu_addr, .iorq_n, .rd_n, .wr_n, .cpu_dout, .cpu_din, .cpu_oe,
    .vcnt, .raster_int_n, .vga_enable, .scanlines_enable, .freq_option, .turbo_option,
    .csync_option, .dev_options
  );

  // scandoubler fields packed back into the register byte
  assign scandbl_out = {turbo_option, csync_option, freq_option, scanlines_enable, vga_enable};

  // --------------------
  // clock and run limit
  initial sysclk = 1'b0;
  always #2 sysclk = ~sysclk;

  always @(posedge sysclk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, the test sequence never finished", cycle_cnt);
      $display("Simulation FAILED");
      $finish;
    end
  end

  // strobe pulses inside the register bus
  always @(posedge sysclk or negedge rst_n) begin
    if (!rst_n) begin
      regwr_cnt    <= 0;
      addr_chg_cnt <= 0;
    end else begin
      if (u_dut.regbus.regwr) regwr_cnt <= regwr_cnt + 1;
      if (u_dut.regbus.regaddr_changed) addr_chg_cnt <= addr_chg_cnt + 1;
    end
  end

  // --------------------
  // checking assertions
  a_read_data: assert property (@(posedge sysclk) disable iff (!rst_n)
    rd_check |-> (cpu_din == exp_din))
    else begin
      rd_errors = rd_errors + 1;
      $display("error %0t cpu_din expected %h got %h", $time, $sampled(exp_din),
               $sampled(cpu_din));
    end

  a_read_oe: assert property (@(posedge sysclk) disable iff (!rst_n)
    rd_check |-> (cpu_oe == exp_oe))
    else begin
      rd_errors = rd_errors + 1;
      $display("error %0t cpu_oe expected %b got %b", $time, $sampled(exp_oe),
               $sampled(cpu_oe));
    end

  // no read strobe, nothing drives the cpu bus
  a_idle_oe: assert property (@(posedge sysclk) disable iff (!rst_n)
    (iorq_n || rd_n) |-> !cpu_oe)
    else begin
      rd_errors = rd_errors + 1;
      $display("error %0t cpu_oe expected 0 got 1 with no read strobe", $time);
    end

  a_scandbl: assert property (@(posedge sysclk) disable iff (!rst_n)
    scandbl_out == exp_scandbl)
    else begin
      cfg_errors = cfg_errors + 1;
      $display("error %0t scandbl fields expected %h got %h", $time, $sampled(exp_scandbl),
               $sampled(scandbl_out));
    end

  a_devopt: assert property (@(posedge sysclk) disable iff (!rst_n)
    dev_options == exp_devopt)
    else begin
      cfg_errors = cfg_errors + 1;
      $display("error %0t dev_options expected %h got %h", $time, $sampled(exp_devopt),
               $sampled(dev_options));
    end

  a_raster_int: assert property (@(posedge sysclk) disable iff (!rst_n)
    raster_int_n == !exp_pend)
    else begin
      int_errors = int_errors + 1;
      $display("error %0t raster_int_n expected %b got %b", $time, $sampled(!exp_pend),
               $sampled(raster_int_n));
    end

  // --------------------
  // expected values
  function automatic cpu_byte_t coreid_char(input int idx);
    if (idx >= `COREID_LEN) return 8'h00;
    // first character sits in the top byte of the string
    return ID_STR[8*(`COREID_LEN-idx)-1 -: 8];
  endfunction

  function automatic int strobe_len();
    return 2 + int'($urandom % 2);
  endfunction

  task automatic expect_read(input logic [15:0] port);
    exp_din = 8'hFF;
    exp_oe  = 1'b0;
    if (port == `ZXUNO_ADDR_PORT) begin
      exp_din = exp_reg;
      exp_oe  = 1'b1;
    end else if (port == `ZXUNO_DATA_PORT) begin
      exp_oe = 1'b1;
      case (exp_reg)
        `REG_SCANDBL:    exp_din = exp_scandbl;
        `REG_DEVOPTIONS: exp_din = exp_devopt;
        `REG_SCRATCH:    exp_din = exp_scratch;
        `REG_RASTERLINE: exp_din = exp_line[7:0];
        `REG_RASTERCTRL: exp_din = {4'b0000, exp_pend, exp_vrd, exp_en, exp_line[8]};
        `REG_COREID:     exp_din = coreid_char(exp_idx);
        default: begin
          // unmapped register, bus floats
          exp_din = 8'hFF;
          exp_oe  = 1'b0;
        end
      endcase
    end
  endtask

  task automatic record_write(input logic [15:0] port, input cpu_byte_t data);
    if (port == `ZXUNO_ADDR_PORT) begin
      exp_reg = data;
      exp_idx = 0;
    end else if (port == `ZXUNO_DATA_PORT) begin
      case (exp_reg)
        `REG_SCANDBL:    exp_scandbl = data;
        `REG_DEVOPTIONS: exp_devopt = data;
        `REG_SCRATCH:    exp_scratch = data;
        `REG_RASTERLINE: exp_line[7:0] = data;
        `REG_RASTERCTRL: begin
          exp_line[8] = data[0];
          exp_en      = data[1];
          exp_vrd     = data[2];
          if (!data[1]) exp_pend = 1'b0;
        end
        default: ;
      endcase
    end
  endtask

  // --------------------
  // cpu bus cycles, driven on the falling edge
  task automatic io_write(input logic [15:0] port, input cpu_byte_t data, input int len);
    int wr_before;
    int chg_before;
    wr_before  = regwr_cnt;
    chg_before = addr_chg_cnt;
    @(negedge sysclk);
    cpu_addr = port;
    cpu_dout = data;
    iorq_n   = 1'b0;
    wr_n     = 1'b0;
    // strobe sampled, then write pulse, then the register holds the byte
    repeat (2) @(posedge sysclk);
    @(negedge sysclk);
    record_write(port, data);
    // rest of a long strobe
    repeat (len - 2) @(negedge sysclk);
    iorq_n = 1'b1;
    wr_n   = 1'b1;
    // one pulse per strobe however long
    if (port == `ZXUNO_DATA_PORT) begin
      assert (regwr_cnt == wr_before + 1) else begin
        strobe_errors = strobe_errors + 1;
        $display("error %0t regwr pulses expected %0d got %0d", $time, wr_before + 1,
                 regwr_cnt);
      end
    end else begin
      assert (addr_chg_cnt == chg_before + 1) else begin
        strobe_errors = strobe_errors + 1;
        $display("error %0t regaddr_changed pulses expected %0d got %0d", $time,
                 chg_before + 1, addr_chg_cnt);
      end
    end
  endtask

  task automatic io_read(input logic [15:0] port);
    int   len;
    logic ctrl_ack;
    len      = strobe_len();
    ctrl_ack = (port == `ZXUNO_DATA_PORT) && (exp_reg == `REG_RASTERCTRL);
    expect_read(port);
    @(negedge sysclk);
    cpu_addr = port;
    iorq_n   = 1'b0;
    rd_n     = 1'b0;
    rd_check = 1'b1;
    repeat (len) @(posedge sysclk);
    @(negedge sysclk);
    iorq_n   = 1'b1;
    rd_n     = 1'b1;
    rd_check = 1'b0;
    if (port == `ZXUNO_DATA_PORT && exp_reg == `REG_COREID && exp_idx < `COREID_LEN) begin
      exp_idx = exp_idx + 1;
    end
    // ctrl read acks the interrupt one cycle after the strobe
    if (ctrl_ack) begin
      @(posedge sysclk);
      @(negedge sysclk);
      exp_pend = 1'b0;
    end
  endtask

  task automatic select_reg(input reg_addr_t num);
    io_write(`ZXUNO_ADDR_PORT, num, strobe_len());
  endtask

  task automatic drive_vcnt(input raster_line_t line);
    logic entering;
    @(negedge sysclk);
    entering = (vcnt != line);
    vcnt     = line;
    // request rises one cycle after the line is entered
    if (entering && exp_en && line == exp_line) begin
      @(posedge sysclk);
      @(negedge sysclk);
      exp_pend = 1'b1;
    end
  endtask

  task automatic idle(input int n);
    repeat (n) @(negedge sysclk);
  endtask

  // --------------------
  // test sequence
  initial begin
    int total;
    void'($urandom(32'h4da68320));
    rst_n         = 1'b0;
    cpu_addr      = 16'h0000;
    iorq_n        = 1'b1;
    rd_n          = 1'b1;
    wr_n          = 1'b1;
    cpu_dout      = 8'h00;
    vcnt          = '0;
    exp_reg       = 8'h00;
    exp_scandbl   = 8'h00;
    exp_devopt    = 8'h00;
    exp_scratch   = 8'h00;
    exp_line      = '0;
    exp_en        = 1'b0;
    exp_vrd       = 1'b0;
    exp_pend      = 1'b0;
    exp_idx       = 0;
    exp_din       = 8'hFF;
    exp_oe        = 1'b0;
    rd_check      = 1'b0;
    rd_errors     = 0;
    cfg_errors    = 0;
    int_errors    = 0;
    strobe_errors = 0;
    repeat (4) @(posedge sysclk);
    @(negedge sysclk);
    rst_n = 1'b1;

    // reset state, address reads back 00
    idle(2);
    io_read(`ZXUNO_ADDR_PORT);

    // address latch readback
    select_reg(`REG_RASTERLINE);
    io_read(`ZXUNO_ADDR_PORT);
    select_reg(8'h5A);
    io_read(`ZXUNO_ADDR_PORT);
    io_read(`ZXUNO_DATA_PORT);

    // config registers, the last round with long strobes
    for (int round = 0; round < 3; round++) begin
      select_reg(`REG_SCANDBL);
      io_write(`ZXUNO_DATA_PORT, cpu_byte_t'($urandom), round == 2 ? 3 : strobe_len());
      io_read(`ZXUNO_DATA_PORT);
      select_reg(`REG_DEVOPTIONS);
      io_write(`ZXUNO_DATA_PORT, cpu_byte_t'($urandom), round == 2 ? 3 : strobe_len());
      io_read(`ZXUNO_DATA_PORT);
      select_reg(`REG_SCRATCH);
      io_write(`ZXUNO_DATA_PORT, cpu_byte_t'($urandom), round == 2 ? 3 : strobe_len());
      io_read(`ZXUNO_DATA_PORT);
    end

    // core id string, then zeros, then restart
    select_reg(`REG_COREID);
    repeat (`COREID_LEN + 2) io_read(`ZXUNO_DATA_PORT);
    select_reg(`REG_COREID);
    io_read(`ZXUNO_DATA_PORT);
    io_read(`ZXUNO_DATA_PORT);

    // raster interrupt enabled
    select_reg(`REG_RASTERLINE);
    io_write(`ZXUNO_DATA_PORT, IRQ_LINE[7:0], strobe_len());
    io_read(`ZXUNO_DATA_PORT);
    select_reg(`REG_RASTERCTRL);
    io_write(`ZXUNO_DATA_PORT, {6'b000000, 1'b1, IRQ_LINE[8]}, strobe_len());
    io_read(`ZXUNO_DATA_PORT);
    drive_vcnt(IRQ_LINE);
    idle(3);
    io_read(`ZXUNO_DATA_PORT);
    idle(3);
    io_read(`ZXUNO_DATA_PORT);
    drive_vcnt(9'h000);

    // raster interrupt disabled, line passes silently
    io_write(`ZXUNO_DATA_PORT, {7'b0000000, IRQ_LINE[8]}, strobe_len());
    drive_vcnt(IRQ_LINE);
    idle(6);
    io_read(`ZXUNO_DATA_PORT);
    drive_vcnt(9'h000);

    // foreign ports stay off the bus
    io_read(16'h00FE);
    io_read(16'h7FFD);
    io_read(16'hFC3A);
    idle(4);

    total = rd_errors + cfg_errors + int_errors + strobe_errors;
    $display("checks done, %0d errors: read %0d, config %0d, interrupt %0d, strobe %0d",
             total, rd_errors, cfg_errors, int_errors, strobe_errors);
    if (total == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* flist.f */
+incdir+hw
hw/zxuno_pkg.sv
hw/zxreg_if.sv
hw/zxuno_regs.sv
hw/cfg_register.sv
hw/coreid_rom.sv
hw/rasterint_ctrl.sv
hw/cpu_din_mux.sv
hw/zxuno_core.sv
bench/tb_zxuno_core.sv

/* Bender.yml */
package:
  name: zxuno_core

sources:
  - include_dirs:
      - hw
    files:
      - hw/zxuno_pkg.sv
      - hw/zxreg_if.sv
      - hw/zxuno_regs.sv
      - hw/cfg_register.sv
      - hw/coreid_rom.sv
      - hw/rasterint_ctrl.sv
      - hw/cpu_din_mux.sv
      - hw/zxuno_core.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - bench/tb_zxuno_core.sv
